// File: rv_core_cfg.svh
/* rv32i core configuration
   widths, reset vector, opcodes and funct3 codes */
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

`define XLEN        32
`define REG_ADDR_W  5
`define NUM_REGS    32
`define RESET_PC    32'h8000_0000

// major opcodes
`define OP_LUI      7'b0110111
`define OP_AUIPC    7'b0010111
`define OP_JAL      7'b1101111
`define OP_JALR     7'b1100111
`define OP_BRANCH   7'b1100011
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011
`define OP_IMM      7'b0010011
`define OP_REG      7'b0110011

// load sizes
`define F3_LB       3'b000
`define F3_LH       3'b001
`define F3_LW       3'b010
`define F3_LBU      3'b100
`define F3_LHU      3'b101
`define F3_SB       3'b000   // store sizes
`define F3_SH       3'b001
`define F3_SW       3'b010
`define F3_BEQ      3'b000   // branch compares
`define F3_BNE      3'b001
`define F3_BLT      3'b100
`define F3_BGE      3'b101
`define F3_BLTU     3'b110
`define F3_BGEU     3'b111

`endif

// File: rv_core_pkg.sv
/* rv32i core types
   records passed between the fetch, decode, execute and memory stages */
`include "rv_core_cfg.svh"

package rv_core_pkg;

    // instruction format
    typedef enum logic [2:0] {
        TYPE_R,
        TYPE_I,
        TYPE_S,
        TYPE_B,
        TYPE_U,
        TYPE_J,
        TYPE_N   // unknown opcode
    } inst_type_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    // request handshake states for both memory ports
    typedef enum logic {
        S_IDLE,
        S_WAIT
    } req_state_t;

    typedef struct packed {
        logic [6:0]             opcode;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`XLEN-1:0]       imm;   // sign extended
        inst_type_t             inst_type;
        alu_op_t                alu_op;
    } decoded_t;

    typedef struct packed {
        logic [`XLEN-1:0] alu_result;
        logic [`XLEN-1:0] jump_target;
        logic             jump_en;
    } exec_t;

    typedef struct packed {
        logic             write;   // 0 for loads
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] wdata;
        logic [3:0]       mask;
    } dmem_req_t;

    typedef struct packed {
        logic [`XLEN-1:0]       pc;
        logic                   wen;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
    } retire_t;

endpackage

// File: rv_fetch.sv
/* instruction fetch
   PC register and one fetch request per instruction */
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_fetch (
    input  logic               clk,
    input  logic               reset,
    output logic               imem_req,
    output logic [`XLEN-1:0]   imem_addr,
    input  logic               imem_rvalid,
    input  logic [`XLEN-1:0]   imem_rdata,
    input  logic               retire_valid,
    input  rv_core_pkg::exec_t exec,
    output logic [`XLEN-1:0]   inst,
    output logic [`XLEN-1:0]   pc,
    output logic [`XLEN-1:0]   snpc,
    output logic               fetched   // inst valid from this cycle
);
    import rv_core_pkg::*;

    req_state_t state;
    logic       boot;   // first fetch not yet issued

    assign imem_addr = pc;   // held until rvalid since pc moves only on retire
    assign snpc      = pc + 'd4;

    // request pulse and wait for the answer
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= S_IDLE;
            boot     <= 1'b1;
            imem_req <= 1'b0;
            fetched  <= 1'b0;
        end else begin
            imem_req <= 1'b0;
            fetched  <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (boot || retire_valid) begin
                        imem_req <= 1'b1;
                        boot     <= 1'b0;
                        state    <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (imem_rvalid) begin
                        fetched <= 1'b1;
                        state   <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_WAIT && imem_rvalid) begin
            inst <= imem_rdata;
        end
    end

    // next pc taken on the retire edge
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else if (retire_valid) begin
            pc <= exec.jump_en ? exec.jump_target : snpc;
        end
    end

endmodule

// File: rv_decode.sv
/* instruction decoder
   format, register fields, immediate and alu operation */
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_decode (
    input  logic [`XLEN-1:0]      inst,
    output rv_core_pkg::decoded_t dec
);
    import rv_core_pkg::*;

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    inst_type_t       itype;
    logic [`XLEN-1:0] imm;
    alu_op_t          alu_op;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];

    always_comb begin
        case (opcode)
            `OP_REG:                      itype = TYPE_R;
            `OP_IMM, `OP_LOAD, `OP_JALR:  itype = TYPE_I;
            `OP_STORE:                    itype = TYPE_S;
            `OP_BRANCH:                   itype = TYPE_B;
            `OP_LUI, `OP_AUIPC:           itype = TYPE_U;
            `OP_JAL:                      itype = TYPE_J;
            default:                      itype = TYPE_N;
        endcase
    end

    // immediate per format, always sign extended from bit 31
    always_comb begin
        case (itype)
            TYPE_I:  imm = {{20{inst[31]}}, inst[31:20]};
            TYPE_S:  imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            TYPE_B:  imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            TYPE_U:  imm = {inst[31:12], 12'h000};
            TYPE_J:  imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

    // everything outside OP/OP-IMM uses the adder
    always_comb begin
        alu_op = ALU_ADD;
        if (opcode == `OP_IMM || opcode == `OP_REG) begin
            case (funct3)
                3'b000: begin
                    if (opcode == `OP_REG && inst[30]) begin
                        alu_op = ALU_SUB;   // no subi
                    end
                end
                3'b001:  alu_op = ALU_SLL;
                3'b010:  alu_op = ALU_SLT;
                3'b011:  alu_op = ALU_SLTU;
                3'b100:  alu_op = ALU_XOR;
                3'b101:  alu_op = inst[30] ? ALU_SRA : ALU_SRL;
                3'b110:  alu_op = ALU_OR;
                default: alu_op = ALU_AND;
            endcase
        end
    end

    always_comb begin
        dec.opcode    = opcode;
        dec.funct3    = funct3;
        dec.rd        = inst[11:7];
        dec.rs1       = inst[19:15];
        dec.rs2       = inst[24:20];
        dec.imm       = imm;
        dec.inst_type = itype;
        dec.alu_op    = alu_op;
    end

endmodule

// File: rv_regfile.sv
/* general register file
   two combinational read ports and one write port, x0 fixed at zero */
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_regfile (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   wen,
    input  logic [`REG_ADDR_W-1:0] waddr,
    input  logic [`XLEN-1:0]       wdata,
    input  logic [`REG_ADDR_W-1:0] raddr1,
    input  logic [`REG_ADDR_W-1:0] raddr2,
    output logic [`XLEN-1:0]       rdata1,
    output logic [`XLEN-1:0]       rdata2
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin   // x0 writes dropped
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: rv_execute.sv
/* execute stage
   operand select, alu, branch compare and jump target */
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_execute (
    input  rv_core_pkg::decoded_t dec,
    input  logic [`XLEN-1:0]      rdata1,
    input  logic [`XLEN-1:0]      rdata2,
    input  logic [`XLEN-1:0]      pc,
    input  logic [`XLEN-1:0]      snpc,
    output rv_core_pkg::exec_t    exec
);
    import rv_core_pkg::*;

    logic [`XLEN-1:0] alu_a;
    logic [`XLEN-1:0] alu_b;
    logic [`XLEN-1:0] alu_y;
    logic [4:0]       shamt;
    logic             take;   // branch condition

    always_comb begin
        case (dec.inst_type)
            TYPE_R: begin
                alu_a = rdata1;
                alu_b = rdata2;
            end
            TYPE_I, TYPE_S: begin
                alu_a = rdata1;   // also load/store address and jalr base
                alu_b = dec.imm;
            end
            TYPE_U: begin
                alu_a = (dec.opcode == `OP_LUI) ? '0 : pc;
                alu_b = dec.imm;
            end
            TYPE_B, TYPE_J: begin
                alu_a = pc;
                alu_b = dec.imm;
            end
            default: begin
                alu_a = rdata1;
                alu_b = rdata2;
            end
        endcase
    end

    assign shamt = alu_b[4:0];

    always_comb begin
        case (dec.alu_op)
            ALU_ADD:  alu_y = alu_a + alu_b;
            ALU_SUB:  alu_y = alu_a - alu_b;
            ALU_SLL:  alu_y = alu_a << shamt;
            ALU_SLT:  alu_y = {{(`XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
            ALU_SLTU: alu_y = {{(`XLEN-1){1'b0}}, alu_a < alu_b};
            ALU_XOR:  alu_y = alu_a ^ alu_b;
            ALU_SRL:  alu_y = alu_a >> shamt;
            ALU_SRA:  alu_y = $signed(alu_a) >>> shamt;
            ALU_OR:   alu_y = alu_a | alu_b;
            default:  alu_y = alu_a & alu_b;
        endcase
    end

    // compares use the registers since the alu computes pc+imm
    always_comb begin
        case (dec.funct3)
            `F3_BEQ:  take = (rdata1 == rdata2);
            `F3_BNE:  take = (rdata1 != rdata2);
            `F3_BLT:  take = ($signed(rdata1) < $signed(rdata2));
            `F3_BGE:  take = ($signed(rdata1) >= $signed(rdata2));
            `F3_BLTU: take = (rdata1 < rdata2);
            `F3_BGEU: take = (rdata1 >= rdata2);
            default:  take = 1'b0;
        endcase
    end

    always_comb begin
        exec.alu_result  = alu_y;
        exec.jump_target = snpc;   // fall through
        exec.jump_en     = 1'b0;
        if (dec.opcode == `OP_JALR) begin
            exec.jump_target = {alu_y[`XLEN-1:1], 1'b0};
            exec.jump_en     = 1'b1;
        end else if (dec.inst_type == TYPE_J) begin
            exec.jump_target = alu_y;
            exec.jump_en     = 1'b1;
        end else if (dec.inst_type == TYPE_B) begin
            exec.jump_target = alu_y;
            exec.jump_en     = take;
        end
    end

endmodule

// File: rv_mem_writeback.sv
/* memory access and write-back
   data port handshake, load extension, register write and retire record */
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_mem_writeback (
    input  logic                   clk,
    input  logic                   reset,
    input  rv_core_pkg::decoded_t  dec,
    input  rv_core_pkg::exec_t     exec,
    input  logic [`XLEN-1:0]       rdata2,
    input  logic [`XLEN-1:0]       snpc,
    input  logic [`XLEN-1:0]       pc,
    input  logic                   fetched,
    output logic                   dmem_req,
    output rv_core_pkg::dmem_req_t dmem_cmd,
    input  logic                   dmem_rvalid,
    input  logic [`XLEN-1:0]       dmem_rdata,
    output logic                   reg_wen,
    output logic [`XLEN-1:0]       reg_wdata,
    output logic                   retire_valid,
    output rv_core_pkg::retire_t   retire
);
    import rv_core_pkg::*;

    req_state_t       state;
    logic             is_load;
    logic             is_store;
    logic             writes_rd;
    logic             mem_done;   // cycle after dmem_rvalid
    logic [3:0]       mask;
    logic [`XLEN-1:0] load_q;
    logic [`XLEN-1:0] load_ext;
    logic [`XLEN-1:0] wb_data;

    assign is_load   = (dec.opcode == `OP_LOAD);
    assign is_store  = (dec.opcode == `OP_STORE);
    assign writes_rd = !(dec.inst_type inside {TYPE_B, TYPE_S, TYPE_N});

    // size mask, address assumed word aligned
    always_comb begin
        case (dec.funct3)
            `F3_SB:  mask = 4'b0001;
            `F3_SH:  mask = 4'b0011;
            `F3_SW:  mask = 4'b1111;
            default: mask = 4'b0000;
        endcase
    end

    assign dmem_req       = fetched && (is_load || is_store);
    assign dmem_cmd.write = is_store;
    assign dmem_cmd.addr  = exec.alu_result;
    assign dmem_cmd.wdata = rdata2;
    assign dmem_cmd.mask  = mask;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= S_IDLE;
            mem_done <= 1'b0;
        end else begin
            mem_done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (dmem_req) begin
                        state <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (dmem_rvalid) begin
                        mem_done <= 1'b1;
                        state    <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_WAIT && dmem_rvalid) begin
            load_q <= dmem_rdata;   // ignored for stores
        end
    end

    always_comb begin
        case (dec.funct3)
            `F3_LB:  load_ext = {{24{load_q[7]}}, load_q[7:0]};
            `F3_LH:  load_ext = {{16{load_q[15]}}, load_q[15:0]};
            `F3_LBU: load_ext = {24'h0, load_q[7:0]};
            `F3_LHU: load_ext = {16'h0, load_q[15:0]};
            default: load_ext = load_q;
        endcase
    end

    always_comb begin
        if (is_load) begin
            wb_data = load_ext;
        end else if (dec.opcode == `OP_JAL || dec.opcode == `OP_JALR) begin
            wb_data = snpc;   // link address
        end else begin
            wb_data = exec.alu_result;
        end
    end

    // non memory ops finish in the fetched cycle
    assign retire_valid = (fetched && !(is_load || is_store)) || mem_done;
    assign reg_wen      = retire_valid && writes_rd;
    assign reg_wdata    = wb_data;

    assign retire.pc   = pc;
    assign retire.wen  = writes_rd;
    assign retire.rd   = dec.rd;
    assign retire.data = writes_rd ? wb_data : '0;

endmodule

// File: rv_core.sv
/* rv32i multi-cycle core
   fetch, decode, execute and memory stages around the register file */
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_core (
    input  logic                   clk,
    input  logic                   reset,
    output logic                   imem_req,
    output logic [`XLEN-1:0]       imem_addr,
    input  logic                   imem_rvalid,
    input  logic [`XLEN-1:0]       imem_rdata,
    output logic                   dmem_req,
    output rv_core_pkg::dmem_req_t dmem_cmd,
    input  logic                   dmem_rvalid,
    input  logic [`XLEN-1:0]       dmem_rdata,
    output logic                   retire_valid,
    output rv_core_pkg::retire_t   retire
);
    import rv_core_pkg::*;

    logic [`XLEN-1:0] inst;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] snpc;
    logic             fetched;
    decoded_t         dec;
    exec_t            exec;
    logic [`XLEN-1:0] rdata1;
    logic [`XLEN-1:0] rdata2;
    logic             reg_wen;
    logic [`XLEN-1:0] reg_wdata;

    rv_fetch u_fetch (
        .clk          (clk),
        .reset        (reset),
        .imem_req     (imem_req),
        .imem_addr    (imem_addr),
        .imem_rvalid  (imem_rvalid),
        .imem_rdata   (imem_rdata),
        .retire_valid (retire_valid),
        .exec         (exec),
        .inst         (inst),
        .pc           (pc),
        .snpc         (snpc),
        .fetched      (fetched)
    );

    rv_decode u_decode (
        .inst (inst),
        .dec  (dec)
    );

    rv_regfile u_regfile (
        .clk    (clk),
        .reset  (reset),
        .wen    (reg_wen),
        .waddr  (dec.rd),
        .wdata  (reg_wdata),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    rv_execute u_execute (
        .dec    (dec),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .pc     (pc),
        .snpc   (snpc),
        .exec   (exec)
    );

    rv_mem_writeback u_mem_writeback (
        .clk          (clk),
        .reset        (reset),
        .dec          (dec),
        .exec         (exec),
        .rdata2       (rdata2),
        .snpc         (snpc),
        .pc           (pc),
        .fetched      (fetched),
        .dmem_req     (dmem_req),
        .dmem_cmd     (dmem_cmd),
        .dmem_rvalid  (dmem_rvalid),
        .dmem_rdata   (dmem_rdata),
        .reg_wen      (reg_wen),
        .reg_wdata    (reg_wdata),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule

// File: tb_rv_core.sv
/* testbench for the rv32i core
   golden program and retire trace checked over memories with random latency */
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module tb_rv_core;
    import rv_core_pkg::*;

    localparam int          GOLDEN_WORDS = 512;
    localparam int          IMEM_WORDS   = 256;
    localparam int          DMEM_WORDS   = 64;
    localparam logic [31:0] DMEM_BASE    = 32'h8000_1000;

    logic             clk;
    logic             reset;
    logic             imem_req;
    logic [`XLEN-1:0] imem_addr;
    logic             imem_rvalid;
    logic [`XLEN-1:0] imem_rdata;
    logic             dmem_req;
    dmem_req_t        dmem_cmd;
    logic             dmem_rvalid;
    logic [`XLEN-1:0] dmem_rdata;
    logic             retire_valid;
    retire_t          retire;

    logic [31:0] golden [GOLDEN_WORDS];
    logic [31:0] imem [IMEM_WORDS];
    logic [31:0] dmem [DMEM_WORDS];
    int          prog_words;
    int          num_records;
    int          num_final;
    int          rec_base;     // first retire record word
    int          final_base;   // first final memory word
    int          retired;
    int          ireq_count;
    integer      seed;
    bit          loaded;

    // memory model state with one request per port
    bit          i_busy;
    int          i_wait;
    logic [31:0] i_addr;
    bit          d_busy;
    int          d_wait;
    dmem_req_t   d_cmd;
    bit          dreq_open;    // data access seen for the current instruction

    rv_core uut (
        .clk          (clk),
        .reset        (reset),
        .imem_req     (imem_req),
        .imem_addr    (imem_addr),
        .imem_rvalid  (imem_rvalid),
        .imem_rdata   (imem_rdata),
        .dmem_req     (dmem_req),
        .dmem_cmd     (dmem_cmd),
        .dmem_rvalid  (dmem_rvalid),
        .dmem_rdata   (dmem_rdata),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic end_with_failure();
        $display("Testbench failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at time %0t: %s", $time, msg);
        end_with_failure();
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at time %0t: %s", $time, msg);
        end_with_failure();
    endtask

    function automatic int pick_latency();
        return 1 + int'($unsigned($random(seed)) % 4);   // 1 to 4 cycles
    endfunction

    function automatic int imem_index(input logic [31:0] addr);
        logic [31:0] off;
        off = addr - `RESET_PC;
        if (off[1:0] != 2'b00 || (off >> 2) >= prog_words) begin
            return -1;
        end
        return int'(off >> 2);
    endfunction

    function automatic int dmem_index(input logic [31:0] addr);
        logic [31:0] off;
        off = addr - DMEM_BASE;
        if (off[1:0] != 2'b00 || off >= DMEM_WORDS * 4) begin
            return -1;
        end
        return int'(off >> 2);
    endfunction

    task automatic load_golden();
        $readmemh("rv_core_golden.txt", golden);
        assert (!$isunknown({golden[0], golden[1], golden[2]}))
            else report_error("golden file missing or without counts");
        prog_words  = golden[0];
        num_records = golden[1];
        num_final   = golden[2];
        rec_base    = 3 + prog_words;
        final_base  = rec_base + 4 * num_records;
        assert (final_base + num_final <= GOLDEN_WORDS && prog_words <= IMEM_WORDS
                && num_final <= DMEM_WORDS)
            else report_error("golden file counts do not fit the memories");
        for (int i = 0; i < prog_words; i++) begin
            imem[i] = golden[3 + i];
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = (DMEM_BASE + 4 * i) ^ 32'hA5A5_5A5A;   // address based fill
        end
        loaded = 1'b1;
    endtask

    task automatic check_retire();
        int base;
        base = rec_base + 4 * retired;
        assert (!i_busy && retired + 1 == ireq_count)
            else report_error("retire without a fetched instruction");
        if (dreq_open) begin
            assert (!d_busy) else report_error("retire before the data access finished");
        end
        assert (retire.pc == golden[base])
            else report_mismatch($sformatf("retire %0d pc %h, expected %h",
                                           retired, retire.pc, golden[base]));
        assert (retire.wen == golden[base + 1][0])
            else report_mismatch($sformatf("retire %0d at %h write flag %b, expected %b",
                                           retired, retire.pc, retire.wen, golden[base + 1][0]));
        if (golden[base + 1][0]) begin
            assert (retire.rd == golden[base + 2][4:0])
                else report_mismatch($sformatf("retire %0d at %h rd %0d, expected %0d",
                                               retired, retire.pc, retire.rd, golden[base + 2]));
            if (golden[base + 2][4:0] != 5'd0) begin   // x0 value is discarded
                assert (retire.data == golden[base + 3])
                    else report_mismatch($sformatf("retire %0d at %h value %h, expected %h",
                                                   retired, retire.pc, retire.data,
                                                   golden[base + 3]));
            end
        end
        dreq_open = 1'b0;
        retired++;
    endtask

    // sampled on the rising edge before the core updates
    task automatic watch_outputs();
        if (retire_valid) begin
            check_retire();
        end
        if (i_busy) begin
            assert (imem_addr == i_addr) else report_mismatch("imem_addr moved while waiting");
        end
        if (d_busy) begin
            assert (dmem_cmd == d_cmd) else report_mismatch("dmem_cmd moved while waiting");
        end
        if (imem_req) begin
            assert (!i_busy) else report_error("imem_req while a fetch is outstanding");
            assert (retired == ireq_count)
                else report_error("imem_req before the previous instruction retired");
            if (ireq_count == 0) begin
                assert (imem_addr == `RESET_PC)
                    else report_mismatch($sformatf("first fetch at %h", imem_addr));
            end
            i_busy = 1'b1;
            i_addr = imem_addr;
            i_wait = pick_latency();
            ireq_count++;
        end
        if (dmem_req) begin
            assert (!d_busy && !dreq_open)
                else report_error("dmem_req while a data access is outstanding");
            assert (retired + 1 == ireq_count && !i_busy)
                else report_error("dmem_req without a fetched instruction");
            d_busy    = 1'b1;
            dreq_open = 1'b1;
            d_cmd     = dmem_cmd;
            d_wait    = pick_latency();
        end
    endtask

    task automatic answer_memories();
        int idx;
        imem_rvalid = 1'b0;
        dmem_rvalid = 1'b0;
        if (i_busy) begin
            i_wait--;
            if (i_wait == 0) begin
                idx = imem_index(i_addr);
                assert (idx >= 0)
                    else report_error($sformatf("fetch outside program at %h", i_addr));
                imem_rdata  = imem[idx];
                imem_rvalid = 1'b1;
                i_busy      = 1'b0;
            end
        end
        if (d_busy) begin
            d_wait--;
            if (d_wait == 0) begin
                idx = dmem_index(d_cmd.addr);
                assert (idx >= 0) else report_error($sformatf("data access outside memory at %h",
                                                              d_cmd.addr));
                if (d_cmd.write) begin
                    for (int b = 0; b < 4; b++) begin
                        if (d_cmd.mask[b]) begin
                            dmem[idx][8*b +: 8] = d_cmd.wdata[8*b +: 8];
                        end
                    end
                    dmem_rdata = '0;
                end else begin
                    dmem_rdata = dmem[idx];
                end
                dmem_rvalid = 1'b1;
                d_busy      = 1'b0;
            end
        end
    endtask

    task automatic check_final_memory();
        for (int i = 0; i < num_final; i++) begin
            assert (dmem[i] == golden[final_base + i])
                else report_mismatch($sformatf("data word %h is %h, expected %h",
                                               DMEM_BASE + 4 * i, dmem[i],
                                               golden[final_base + i]));
        end
    endtask

    initial begin
        reset       = 1'b1;
        imem_rvalid = 1'b0;
        imem_rdata  = '0;
        dmem_rvalid = 1'b0;
        dmem_rdata  = '0;
        seed        = 86429;
        loaded      = 1'b0;
        retired     = 0;
        ireq_count  = 0;
        i_busy      = 1'b0;
        i_wait      = 0;
        d_busy      = 1'b0;
        d_wait      = 0;
        dreq_open   = 1'b0;
        load_golden();
        for (int c = 0; c < 5; c++) begin
            @(posedge clk);
            if (c > 0) begin   // outputs unknown before the first reset edge
                assert (!imem_req && !dmem_req && !retire_valid)
                    else report_mismatch("request or retire active during reset");
            end
        end
        #1;
        reset = 1'b0;
        while (retired < num_records) begin
            @(posedge clk);
            watch_outputs();
            #1;
            answer_memories();
        end
        check_final_memory();
        $display("%0d instructions retired", retired);
        $display("Testbench passed");
        $finish;
    end

    // allows about 12 cycles per instruction plus reset and slack
    initial begin
        wait (loaded);
        repeat (num_records * 12 + 100) @(posedge clk);
        $display("timeout: only %0d of %0d instructions retired", retired, num_records);
        end_with_failure();
    end

endmodule

// File: rv_core_golden.txt
// counts: program words, retire records, final data words; then program words,
// retire records (pc, write flag, rd, value), final data words from 0x80001000
3c 33 3
// program from 0x80000000
800010B7 FFB00113 00300193 00310233 402182B3 00319333 003123B3 00313433
003144B3 00315533 403155B3 00316633 003176B3 00419713 FFC12793 FFF1B813
7FF14893 01C15913 40115993 1001EA13 0FF17A93 00001B17 00718013 00300BB3
00318463 00100C13 00310463 00311463 00200C13 00319463 00314463 00300C13
0021C463 0021D463 00400C13 00315463 0021E463 00500C13 00316463 00317463
00600C13 0021F463 00800CEF 00700C13 00000D17 011D0DE7 00800C13 00900C13
0020A023 0030A223 00908223 0030A423 01109423 01409023 00408E03 0040CE83
00809F03 0080DF83 0000AC03 0000006F
// retire records
80000000 1 01 80001000   80000004 1 02 FFFFFFFB   80000008 1 03 00000003
8000000C 1 04 FFFFFFFE   80000010 1 05 00000008   80000014 1 06 00000018
80000018 1 07 00000001   8000001C 1 08 00000000   80000020 1 09 FFFFFFF8
80000024 1 0A 1FFFFFFF   80000028 1 0B FFFFFFFF   8000002C 1 0C FFFFFFFB
80000030 1 0D 00000003   80000034 1 0E 00000030   80000038 1 0F 00000001
8000003C 1 10 00000001   80000040 1 11 FFFFF804   80000044 1 12 0000000F
80000048 1 13 FFFFFFFD   8000004C 1 14 00000103   80000050 1 15 000000FB
80000054 1 16 80001054   80000058 1 00 00000000   8000005C 1 17 00000003
80000060 0 00 00000000   80000068 0 00 00000000   8000006C 0 00 00000000
80000074 0 00 00000000   80000078 0 00 00000000   80000080 0 00 00000000
80000084 0 00 00000000   8000008C 0 00 00000000   80000090 0 00 00000000
80000098 0 00 00000000   8000009C 0 00 00000000   800000A4 0 00 00000000
800000A8 1 19 800000AC   800000B0 1 1A 800000B0   800000B4 1 1B 800000B8
800000C0 0 00 00000000   800000C4 0 00 00000000   800000C8 0 00 00000000
800000CC 0 00 00000000   800000D0 0 00 00000000   800000D4 0 00 00000000
800000D8 1 1C FFFFFFF8   800000DC 1 1D 000000F8   800000E0 1 1E FFFFF804
800000E4 1 1F 0000F804   800000E8 1 18 FFFF0103   800000EC 1 00 00000000
// final data memory words
FFFF0103 000000F8 0000F804

// File: rv_core.f
+incdir+.
rv_core_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_regfile.sv
rv_execute.sv
rv_mem_writeback.sv
rv_core.sv
tb_rv_core.sv
